/* eeprom_cfg.svh */
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// CLK cycles per quarter of an SCL period
`define EEPROM_DIV 2

// command queue depth, also the host's starting credits
`define EEPROM_CMD_DEPTH 4

// 24Cxx device type code
`define EEPROM_DEV_CODE 4'b1010

`endif

/* eeprom_pkg.sv */
package eeprom_pkg;

    // host command, data ignored on reads
    typedef struct packed {
        logic        write;
        logic [10:0] addr;
        logic [7:0]  data;
    } eeprom_cmd_t;

    // operations understood by the bit engine
    typedef enum logic [2:0] {
        op_start,
        op_restart,
        op_write,
        op_read_nack,
        op_stop
    } byte_op_t;

    typedef struct packed {
        logic [7:0] data;
        logic       nack;   // slave refused a byte
    } eeprom_rsp_t;

endpackage

/* i2c_byte_if.sv */
interface i2c_byte_if;

    logic                 req;
    eeprom_pkg::byte_op_t op;
    logic [7:0]           wdata;
    logic                 done;     // one cycle pulse
    logic [7:0]           rdata;
    logic                 ack;      // valid with done of op_write

    modport seq (
        output req, op, wdata,
        input  done, rdata, ack
    );

    modport eng (
        input  req, op, wdata,
        output done, rdata, ack
    );

endinterface

/* i2c_cmd_fifo.sv */
`include "eeprom_cfg.svh"

module i2c_cmd_fifo (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    push,
    input  eeprom_pkg::eeprom_cmd_t push_cmd,
    input  logic                    pop,
    output eeprom_pkg::eeprom_cmd_t head_cmd,
    output logic                    empty,
    output logic                    credit
);
    import eeprom_pkg::*;

    localparam int DEPTH = `EEPROM_CMD_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    eeprom_cmd_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        ptr_inc = (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_cmd = mem[rd_ptr];
    assign empty    = (count == '0);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            credit <= pop;  // each pop hands one credit back
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (push)
            mem[wr_ptr] <= push_cmd;
    end

endmodule

/* i2c_bit_engine.sv */
`include "eeprom_cfg.svh"

module i2c_bit_engine (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     sda_in,
    i2c_byte_if.eng  byte_if,
    output logic     scl,
    output logic     sda_out,
    output logic     sda_oe
);
    import eeprom_pkg::*;

    localparam int DIV = `EEPROM_DIV;
    localparam int QW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic          busy;
    logic          done_r;
    byte_op_t      op_r;
    logic [1:0]    phase;
    logic [QW-1:0] q_cnt;
    logic [3:0]    bit_cnt;
    logic [7:0]    shreg;
    logic [7:0]    rdata_r;
    logic          ack_r;
    logic          start_op;
    logic          tick;
    logic          last_bit;
    logic          scl_lvl;
    logic          low_lvl;

    assign start_op = !busy && byte_if.req && !done_r;
    assign tick     = (q_cnt == QW'(DIV - 1));
    assign last_bit = (bit_cnt == 4'd8);    // ninth bit is the acknowledge

    assign byte_if.done  = done_r;
    assign byte_if.rdata = rdata_r;
    assign byte_if.ack   = ack_r;

    // open drain pad, only ever pulls low
    assign sda_out = 1'b0;

    // line levels per quarter phase, scl high in phases 1 and 2
    always_comb
    begin
        scl_lvl = (phase == 2'd1) || (phase == 2'd2);
        low_lvl = 1'b0;
        case (op_r)
            op_start:
            begin
                scl_lvl = (phase != 2'd3);  // bus idle, scl already high
                low_lvl = phase[1];
            end
            op_restart:
                low_lvl = phase[1];
            op_write:
                low_lvl = !last_bit && !shreg[7];
            op_stop:
            begin
                scl_lvl = (phase != 2'd0);
                low_lvl = !phase[1];        // sda rises with scl high
            end
            default:
                low_lvl = 1'b0;             // read and nack leave sda released
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            done_r  <= 1'b0;
            op_r    <= op_stop;
            phase   <= 2'd0;
            q_cnt   <= '0;
            bit_cnt <= 4'd0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else
        begin
            done_r <= 1'b0;
            if (start_op)
            begin
                busy    <= 1'b1;
                op_r    <= byte_if.op;
                phase   <= 2'd0;
                q_cnt   <= '0;
                bit_cnt <= 4'd0;
            end
            else if (busy)
            begin
                scl    <= scl_lvl;
                sda_oe <= low_lvl;
                q_cnt  <= tick ? '0 : q_cnt + 1'b1;
                if (tick)
                begin
                    phase <= phase + 2'd1;
                    if (phase == 2'd3)
                    begin
                        if ((op_r == op_write || op_r == op_read_nack) && !last_bit)
                            bit_cnt <= bit_cnt + 4'd1;
                        else
                        begin
                            busy   <= 1'b0;
                            done_r <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start_op)
            shreg <= byte_if.wdata;
        else if (busy && tick)
        begin
            if (phase == 2'd1 && op_r == op_read_nack && !last_bit)
                rdata_r <= {rdata_r[6:0], sda_in};  // msb first, mid scl high
            if (phase == 2'd1 && op_r == op_write && last_bit)
                ack_r <= !sda_in;
            if (phase == 2'd3 && !last_bit)
                shreg <= {shreg[6:0], 1'b0};
        end
    end

endmodule

/* eeprom_sequencer.sv */
`include "eeprom_cfg.svh"

module eeprom_sequencer (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    fifo_empty,
    input  eeprom_pkg::eeprom_cmd_t head_cmd,
    output logic                    pop,
    output logic                    rsp_valid,
    output logic [7:0]              rsp_data,
    output logic                    rsp_nack,
    i2c_byte_if.seq                 byte_if
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        s_idle,
        s_start,
        s_ctrl_w,
        s_addr,
        s_data,
        s_restart,
        s_ctrl_r,
        s_read,
        s_stop
    } state_t;

    state_t      state;
    state_t      step_next;
    byte_op_t    step_op;
    logic [7:0]  step_wdata;
    logic        refused;
    eeprom_cmd_t cmd_r;
    eeprom_rsp_t rsp_r;

    assign rsp_data = rsp_r.data;
    assign rsp_nack = rsp_r.nack;
    assign refused  = (step_op == op_write) && !byte_if.ack;

    // op and byte for the current step
    always_comb
    begin
        step_op    = op_write;
        step_wdata = 8'h00;
        step_next  = s_idle;
        case (state)
            s_start:
            begin
                step_op   = op_start;
                step_next = s_ctrl_w;
            end
            s_ctrl_w:
            begin
                step_wdata = {`EEPROM_DEV_CODE, cmd_r.addr[10:8], 1'b0};
                step_next  = s_addr;
            end
            s_addr:
            begin
                step_wdata = cmd_r.addr[7:0];
                step_next  = cmd_r.write ? s_data : s_restart;
            end
            s_data:
            begin
                step_wdata = cmd_r.data;
                step_next  = s_stop;
            end
            s_restart:
            begin
                step_op   = op_restart;
                step_next = s_ctrl_r;
            end
            s_ctrl_r:
            begin
                step_wdata = {`EEPROM_DEV_CODE, cmd_r.addr[10:8], 1'b1};
                step_next  = s_read;
            end
            s_read:
            begin
                step_op   = op_read_nack;
                step_next = s_stop;
            end
            s_stop:
                step_op = op_stop;
            default:
                step_next = s_idle;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= s_idle;
            pop         <= 1'b0;
            rsp_valid   <= 1'b0;
            byte_if.req <= 1'b0;
        end
        else
        begin
            pop       <= 1'b0;
            rsp_valid <= 1'b0;
            if (state == s_idle)
            begin
                if (!fifo_empty)
                begin
                    pop   <= 1'b1;
                    state <= s_start;
                end
            end
            else if (!byte_if.req)
                byte_if.req <= 1'b1;
            else if (byte_if.done)
            begin
                byte_if.req <= 1'b0;
                rsp_valid   <= (state == s_stop);
                state       <= refused ? s_stop : step_next;   // skip to stop on nack
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == s_idle && !fifo_empty)
        begin
            cmd_r <= head_cmd;
            rsp_r <= '0;
        end
        else if (!byte_if.req)
        begin
            byte_if.op    <= step_op;
            byte_if.wdata <= step_wdata;
        end
        else if (byte_if.done)
        begin
            if (refused)
                rsp_r.nack <= 1'b1;
            if (state == s_read)
                rsp_r.data <= byte_if.rdata;
        end
    end

endmodule

/* eeprom_ctrl_top.sv */
module eeprom_ctrl_top (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        cmd_valid,
    input  logic        cmd_write,
    input  logic [10:0] cmd_addr,
    input  logic [7:0]  cmd_data,
    output logic        cmd_credit,
    output logic        rsp_valid,
    output logic [7:0]  rsp_data,
    output logic        rsp_nack,
    output logic        scl,
    output logic        sda_out,
    output logic        sda_oe,
    input  logic        sda_in
);
    import eeprom_pkg::*;

    eeprom_cmd_t push_cmd;
    eeprom_cmd_t head_cmd;
    logic        fifo_empty;
    logic        pop;

    i2c_byte_if byte_if ();

    assign push_cmd = '{write: cmd_write, addr: cmd_addr, data: cmd_data};

    i2c_cmd_fifo fifo0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .push     (cmd_valid),
        .push_cmd (push_cmd),
        .pop      (pop),
        .head_cmd (head_cmd),
        .empty    (fifo_empty),
        .credit   (cmd_credit)
    );

    eeprom_sequencer seq0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .fifo_empty (fifo_empty),
        .head_cmd   (head_cmd),
        .pop        (pop),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_nack   (rsp_nack),
        .byte_if    (byte_if.seq)
    );

    i2c_bit_engine eng0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .sda_in  (sda_in),
        .byte_if (byte_if.eng),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe)
    );

endmodule

/* eeprom_model.sv */
`include "eeprom_cfg.svh"

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic nack_all,
    output logic pull_low
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        st_idle,
        st_ctrl,
        st_addr,
        st_wdata,
        st_tx
    } mstate_t;

    logic [7:0]  mem [2048];
    mstate_t     st;
    mstate_t     nxt;
    logic [7:0]  shreg;
    logic [10:0] ptr;
    int          cnt;
    logic        scl_q;
    logic        sda_q;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0];    // unwritten bytes read back as their low address
        st       = st_idle;
        nxt      = st_idle;
        pull_low = 1'b0;
        cnt      = 0;
        ptr      = '0;
        scl_q    = 1'b1;
        sda_q    = 1'b1;
    end

    // ack decision after the eighth bit of a received byte
    task automatic accept_byte();
        logic ack;
        ack = 1'b0;
        nxt = st_idle;
        case (st)
            st_ctrl:
                if (shreg[7:4] == `EEPROM_DEV_CODE && !nack_all)
                begin
                    ack       = 1'b1;
                    ptr[10:8] = shreg[3:1];     // page bits from device select
                    nxt       = shreg[0] ? st_tx : st_addr;
                end
            st_addr:
                if (!nack_all)
                begin
                    ack      = 1'b1;
                    ptr[7:0] = shreg;
                    nxt      = st_wdata;
                end
            st_wdata:
                if (!nack_all)
                begin
                    ack      = 1'b1;
                    mem[ptr] = shreg;
                end
            default:
                nxt = st_idle;
        endcase
        pull_low = ack;
    endtask

    task automatic on_rise();
        if (st == st_tx)
        begin
            if (cnt == 8 && sda)
                st = st_idle;           // master nack ends the read
            cnt++;
        end
        else if (st != st_idle)
        begin
            if (cnt < 8)
                shreg = {shreg[6:0], sda};
            cnt++;
        end
    endtask

    task automatic on_fall();
        if (st == st_tx)
        begin
            if (cnt >= 1 && cnt <= 7)
            begin
                shreg    = {shreg[6:0], 1'b0};
                pull_low = !shreg[7];
            end
            else if (cnt == 8)
                pull_low = 1'b0;        // let the master answer
        end
        else if (st != st_idle)
        begin
            if (cnt == 8)
                accept_byte();
            else if (cnt == 9)
            begin
                pull_low = 1'b0;
                cnt      = 0;
                st       = nxt;
                if (st == st_tx)
                begin
                    shreg    = mem[ptr];
                    pull_low = !shreg[7];
                end
            end
        end
    endtask

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            st       = st_ctrl;         // start or repeated start
            cnt      = 0;
            pull_low = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            st       = st_idle;         // stop
            pull_low = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b0)
            on_rise();
        else if (scl === 1'b0 && scl_q === 1'b1)
            on_fall();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* tb_eeprom_ctrl.sv */
`include "eeprom_cfg.svh"

module tb_eeprom_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH  = `EEPROM_CMD_DEPTH;
    localparam int N_CMDS = 6 + 1 + DEPTH + 3;
    localparam int LIMIT  = N_CMDS * 45 * 4 * `EEPROM_DIV + 200;

    logic        CLK;
    logic        RESET;
    logic        cmd_valid;
    logic        cmd_write;
    logic [10:0] cmd_addr;
    logic [7:0]  cmd_data;
    logic        cmd_credit;
    logic        rsp_valid;
    logic [7:0]  rsp_data;
    logic        rsp_nack;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    logic        model_pull;
    logic        nack_all;
    wire         sda;

    logic [8:0]  exp_mem [32];     // {data, nack} in command order
    int          exp_wr = 0;
    int          exp_rd = 0;
    int          credits = 0;
    int          credit_pulses = 0;
    int          sent = 0;
    int          stops = 0;
    int          errors = 0;
    int          errs_at_start = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          cycles = 0;
    string       test_name = "none";

    // open drain line with pull-up
    assign sda = (sda_oe ? sda_out : 1'b1) & !model_pull;

    eeprom_ctrl_top dut0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_write  (cmd_write),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_nack   (rsp_nack),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe),
        .sda_in     (sda)
    );

    eeprom_model model0 (
        .scl      (scl),
        .sda      (sda),
        .nack_all (nack_all),
        .pull_low (model_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // host side credit count
    always @(posedge CLK)
    begin
        if (RESET)
            credits <= DEPTH;
        else
        begin
            credits <= credits + (cmd_credit ? 1 : 0) - (cmd_valid ? 1 : 0);
            if (cmd_credit)
                credit_pulses <= credit_pulses + 1;
        end
    end

    // retire the expected entry on the edge where the assertions see the pulse
    always @(posedge CLK)
    begin
        if (rsp_valid && exp_rd != exp_wr)
            exp_rd <= exp_rd + 1;
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
            stops = stops + 1;
    end

    a_no_spurious: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |-> exp_rd != exp_wr)
    else
    begin
        errors++;
        $display("%s: response pulse arrived with no command outstanding", test_name);
    end

    a_rsp_value: assert property (@(posedge CLK) disable iff (RESET)
        (rsp_valid && exp_rd != exp_wr) |-> {rsp_data, rsp_nack} == exp_mem[exp_rd])
    else
    begin
        errors++;
        $display("FAIL %s: expected data %h nack %b, actual data %h nack %b", test_name,
                 exp_mem[$sampled(exp_rd)][8:1], exp_mem[$sampled(exp_rd)][0],
                 $sampled(rsp_data), $sampled(rsp_nack));
    end

    task automatic send(input logic wr, input logic [10:0] a, input logic [7:0] d,
                        input logic [8:0] exp);
        @(negedge CLK);
        while (credits == 0)
        begin
            cmd_valid = 1'b0;
            @(negedge CLK);
        end
        cmd_valid       = 1'b1;
        cmd_write       = wr;
        cmd_addr        = a;
        cmd_data        = d;
        exp_mem[exp_wr] = exp;
        exp_wr          = exp_wr + 1;
        sent            = sent + 1;
    endtask

    task automatic drain();
        @(negedge CLK);
        cmd_valid = 1'b0;
        while (exp_rd != exp_wr)
            @(negedge CLK);
        repeat (4) @(negedge CLK);
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = errors;
    endtask

    task automatic report_test();
        tests++;
        if (errors == errs_at_start)
            $display("test %s passed", test_name);
        else
        begin
            failed_tests++;
            $display("test %s failed with %0d errors", test_name, errors - errs_at_start);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        assert (exp == act)
        else
        begin
            errors++;
            $display("FAIL %s: %s expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    initial
    begin
        logic [2:0]  base;
        logic [7:0]  lo;
        logic [10:0] addr [3];
        logic [7:0]  data [3];
        logic [10:0] cf_addr [DEPTH];
        logic [7:0]  cf_data [DEPTH];
        logic [10:0] fresh;
        int          cp0;
        int          s0;
        int          st0;

        void'($urandom(31975));
        RESET     = 1'b1;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr  = '0;
        cmd_data  = '0;
        nack_all  = 1'b0;
        repeat (10) @(negedge CLK);
        RESET = 1'b0;

        start_test("after_reset");
        @(negedge CLK);
        assert ({rsp_valid, cmd_credit, scl, sda_oe} == 4'b0010)
        else
        begin
            errors++;
            $display("FAIL %s: expected rsp_valid,cmd_credit,scl,sda_oe 0010, actual %b%b%b%b",
                     test_name, rsp_valid, cmd_credit, scl, sda_oe);
        end
        repeat (50) @(negedge CLK);    // any pulse here trips a_no_spurious
        report_test();

        start_test("write_read");
        base = 3'($urandom);
        lo   = 8'($urandom);           // same low byte on every page
        for (int i = 0; i < 3; i++)
        begin
            addr[i] = {3'(base + 3 * i), lo};
            data[i] = {5'($urandom), 3'(i)};
            if (data[i] == lo)
                data[i] = ~data[i];
            send(1'b1, addr[i], data[i], 9'h000);
        end
        for (int i = 0; i < 3; i++)
            send(1'b0, addr[i], 8'h00, {data[i], 1'b0});
        drain();
        report_test();

        start_test("unwritten");
        fresh = {3'(base + 1), lo};
        send(1'b0, fresh, 8'h00, {fresh[7:0], 1'b0});
        drain();
        report_test();

        start_test("credit_flow");
        cp0 = credit_pulses;
        s0  = sent;
        for (int i = 0; i < DEPTH; i++)
        begin
            cf_addr[i] = {3'(base + 2), 8'((8'($urandom) & 8'hf0) | 8'(i))};
            cf_data[i] = 8'($urandom);
            if (cf_data[i] == cf_addr[i][7:0])
                cf_data[i] = ~cf_data[i];
        end
        // first half writes, second half reads them back, no gaps
        for (int i = 0; i < DEPTH; i++)
        begin
            if (i < DEPTH / 2)
                send(1'b1, cf_addr[i], cf_data[i], 9'h000);
            else
                send(1'b0, cf_addr[i - DEPTH / 2], 8'h00, {cf_data[i - DEPTH / 2], 1'b0});
        end
        drain();
        check_count("credit pulses", sent - s0, credit_pulses - cp0);
        report_test();

        start_test("forced_nack");
        nack_all = 1'b1;
        st0      = stops;
        send(1'b1, addr[0], ~data[0], 9'h001);
        drain();
        check_count("stop conditions", st0 + 1, stops);
        st0 = stops;
        send(1'b0, addr[0], 8'h00, 9'h001);
        drain();
        check_count("stop conditions", st0 + 1, stops);
        nack_all = 1'b0;
        send(1'b0, addr[0], 8'h00, {data[0], 1'b0});    // refused write left it alone
        drain();
        report_test();

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        while (cycles < LIMIT)
        begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout after %0d cycles in %s, responses stopped arriving", cycles, test_name);
        $display("Errors found");
        $finish;
    end

endmodule

/* eeprom_ctrl_top.f */
+incdir+.
eeprom_pkg.sv
i2c_byte_if.sv
i2c_cmd_fifo.sv
i2c_bit_engine.sv
eeprom_sequencer.sv
eeprom_ctrl_top.sv
eeprom_model.sv
tb_eeprom_ctrl.sv
